/* common/fas_params.svh */
`ifndef FAS_PARAMS_SVH
`define FAS_PARAMS_SVH

// sample and coefficient width, both two's complement
`define FAS_SAMPLE_W 16

// symmetric low-pass filter
`define FAS_TAPS 32  // full window length
`define FAS_PAIRS 16  // taps folded into symmetric pairs

// accumulator width, products and tree wrap mod 2^32
`define FAS_ACC_W 32

// filtered samples per peak search frame
`define FAS_FRAME_LEN 16

`endif

/* common/fas_fir_pkg.sv */
`default_nettype none

`include "fas_params.svh"

package fas_fir_pkg;

	typedef logic signed [`FAS_SAMPLE_W-1:0] sample_t;  // filter in and out
	typedef logic signed [`FAS_SAMPLE_W-1:0] coeff_t;  // q15 coefficient
	typedef logic signed [`FAS_SAMPLE_W:0] pair_t;  // one guard bit for the pre-add
	typedef logic signed [`FAS_ACC_W-1:0] acc_t;  // products and adder tree

	// half of the symmetric impulse response
	// entry k weights tap k and tap 31-k
	parameter coeff_t fir_coeffs [`FAS_PAIRS] = '{
		16'hFF9E,  // outermost pair
		16'hFF86,
		16'hFFA7,
		16'h003B,
		16'h014B,
		16'h024A,
		16'h0222,
		16'hFFE4,
		16'hFBC5,  // negative side lobe
		16'hF7CA,
		16'hF74E,
		16'hFD74,
		16'h0B1A,
		16'h1DAC,
		16'h2F9E,
		16'h3AA9  // centre pair, largest weight
	};

endpackage

`default_nettype wire

/* common/fas_peak_pkg.sv */
`default_nettype none

`include "fas_params.svh"

package fas_peak_pkg;

	// square of a filtered sample, never negative
	typedef logic [2*`FAS_SAMPLE_W-1:0] power_t;

	// position of a sample inside its frame
	typedef logic [$clog2(`FAS_FRAME_LEN)-1:0] bin_idx_t;

endpackage

`default_nettype wire

/* fir/fir_tap_line.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fas_params.svh"

module fir_tap_line (
	input  wire clk,
	input  wire rst,
	input  wire data_valid,  // one sample per high cycle
	input  wire fas_fir_pkg::sample_t data,
	output fas_fir_pkg::pair_t pair_sums [`FAS_PAIRS],  // to the multipliers
	output logic window_valid  // full window was just shifted in
);

	localparam int FILL_W = $clog2(`FAS_TAPS + 1);  // must reach 32

	fas_fir_pkg::sample_t taps [`FAS_TAPS];  // tap 0 is the newest sample
	logic [FILL_W-1:0] fill;  // samples held since reset, saturates

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < `FAS_TAPS; i++) begin
				taps[i] <= '0;  // empty line after reset
			end
			fill <= '0;
			window_valid <= 1'b0;
		end else begin
			// fill >= 31 here means the line holds 32 after this shift
			window_valid <= data_valid && (fill >= FILL_W'(`FAS_TAPS - 1));
			if (data_valid) begin
				taps[0] <= data;
				for (int i = 1; i < `FAS_TAPS; i++) begin
					taps[i] <= taps[i-1];  // age by one position
				end
				if (fill < FILL_W'(`FAS_TAPS)) begin
					fill <= fill + 1'b1;
				end
			end
		end
	end

	// symmetric pre-add, halves the multiplier count
	always_comb begin
		for (int k = 0; k < `FAS_PAIRS; k++) begin
			pair_sums[k] = fas_fir_pkg::pair_t'(taps[k])  // sign extend
				+ fas_fir_pkg::pair_t'(taps[`FAS_TAPS-1-k]);
		end
	end

endmodule

`default_nettype wire

/* fir/fir_mac.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fas_params.svh"

module fir_mac (
	input  wire clk,
	input  wire rst,
	input  wire fas_fir_pkg::pair_t pair_sums [`FAS_PAIRS],  // from the tap line
	input  wire window_valid,  // pair sums hold a full window
	output fas_fir_pkg::sample_t fir_d,  // held between strobes
	output logic fir_valid
);

	fas_fir_pkg::acc_t prod [`FAS_PAIRS];  // one per symmetric pair
	fas_fir_pkg::acc_t lvl1 [`FAS_PAIRS/2];
	fas_fir_pkg::acc_t lvl2 [`FAS_PAIRS/4];
	fas_fir_pkg::acc_t lvl3 [`FAS_PAIRS/8];
	fas_fir_pkg::acc_t sum;  // full filter sum, wraps
	fas_fir_pkg::sample_t rounded;

	// coefficient products, both operands widened first
	always_comb begin
		for (int k = 0; k < `FAS_PAIRS; k++) begin
			prod[k] = fas_fir_pkg::acc_t'(pair_sums[k])
				* fas_fir_pkg::acc_t'(fas_fir_pkg::fir_coeffs[k]);
		end
	end

	// balanced adder tree, 16 -> 8 -> 4 -> 2 -> 1
	always_comb begin
		for (int i = 0; i < `FAS_PAIRS/2; i++) begin
			lvl1[i] = prod[2*i] + prod[2*i+1];
		end
		for (int i = 0; i < `FAS_PAIRS/4; i++) begin
			lvl2[i] = lvl1[2*i] + lvl1[2*i+1];
		end
		for (int i = 0; i < `FAS_PAIRS/8; i++) begin
			lvl3[i] = lvl2[2*i] + lvl2[2*i+1];
		end
		sum = lvl3[0] + lvl3[1];
	end

	// upper half of the sum, negative values bumped by one
	assign rounded = fas_fir_pkg::sample_t'(sum[`FAS_ACC_W-1 -: `FAS_SAMPLE_W])
		+ fas_fir_pkg::sample_t'(sum[`FAS_ACC_W-1]);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			fir_valid <= 1'b0;
		end else begin
			fir_valid <= window_valid;  // one cycle behind the tap line
		end
	end

	// data register only loads on a strobe
	always_ff @(posedge clk) begin
		if (window_valid) begin
			fir_d <= rounded;
		end
	end

endmodule

`default_nettype wire

/* design/peak_finder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fas_params.svh"

module peak_finder (
	input  wire clk,
	input  wire rst,
	input  wire fir_valid,  // one filtered sample per strobe
	input  wire fas_fir_pkg::sample_t fir_d,
	output logic done,  // end of frame, one cycle
	output fas_peak_pkg::bin_idx_t freq  // best position of last frame
);

	localparam fas_peak_pkg::bin_idx_t LAST_POS =
		fas_peak_pkg::bin_idx_t'(`FAS_FRAME_LEN - 1);

	logic signed [2*`FAS_SAMPLE_W-1:0] square;  // signed product, always >= 0
	fas_peak_pkg::power_t power;
	fas_peak_pkg::bin_idx_t pos;  // position of the incoming sample
	fas_peak_pkg::power_t best_pow;  // best so far in this frame
	fas_peak_pkg::bin_idx_t best_pos;
	logic win;  // incoming sample beats the current best
	fas_peak_pkg::bin_idx_t cand_pos;  // best position including this sample

	assign square = fir_d * fir_d;  // operands widen to 32 bits
	assign power = fas_peak_pkg::power_t'(square);

	// first sample of a frame always wins
	// strictly greater only, so ties stay with the earlier position
	assign win = (pos == '0) || (power > best_pow);
	assign cand_pos = win ? pos : best_pos;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pos <= '0;
			done <= 1'b0;
			freq <= '0;
		end else begin
			done <= fir_valid && (pos == LAST_POS);
			if (fir_valid) begin
				if (pos == LAST_POS) begin
					pos <= '0;  // next frame
					freq <= cand_pos;  // publish with done
				end else begin
					pos <= pos + 1'b1;
				end
			end
		end
	end

	// running best, reloaded at position 0 of every frame
	always_ff @(posedge clk) begin
		if (fir_valid && win) begin
			best_pow <= power;
			best_pos <= pos;
		end
	end

endmodule

`default_nettype wire

/* design/fas_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fas_params.svh"

module fas_top (
	input  wire clk,
	input  wire rst,
	input  wire data_valid,  // no back-pressure, every sample is taken
	input  wire fas_fir_pkg::sample_t data,
	output wire fas_fir_pkg::sample_t fir_d,  // filtered stream
	output wire fir_valid,
	output wire done,  // frame result strobe
	output wire fas_peak_pkg::bin_idx_t freq
);

	wire fas_fir_pkg::pair_t pair_sums [`FAS_PAIRS];  // tap line to mac
	wire window_valid;

	// delay line and symmetric pre-add
	fir_tap_line i_tap_line (
		.clk          (clk),
		.rst          (rst),
		.data_valid   (data_valid),
		.data         (data),
		.pair_sums    (pair_sums),
		.window_valid (window_valid)
	);

	// products, tree and output register
	fir_mac i_mac (
		.clk          (clk),
		.rst          (rst),
		.pair_sums    (pair_sums),
		.window_valid (window_valid),
		.fir_d        (fir_d),
		.fir_valid    (fir_valid)
	);

	// per-frame peak search on the filter output
	peak_finder i_peak (
		.clk       (clk),
		.rst       (rst),
		.fir_valid (fir_valid),
		.fir_d     (fir_d),
		.done      (done),
		.freq      (freq)
	);

endmodule

`default_nettype wire

/* verification/fas_props.sv */
`timescale 1ns/10ps
`default_nettype none

module fas_props (
	input wire clk,
	input wire rst,
	input wire data_valid,
	input wire fir_valid,
	input wire done,
	input wire fas_peak_pkg::bin_idx_t freq
);

	int unsigned fail_count = 0;  // summed into the testbench error total

	// tap line plus mac register, two stages
	a_fir_src: assert property (@(posedge clk) disable iff (rst)
		fir_valid |-> $past(data_valid, 2))
	else begin
		fail_count++;
		$error("fir_valid without data_valid two cycles earlier");
	end

	a_done_src: assert property (@(posedge clk) disable iff (rst)
		done |-> $past(fir_valid))
	else begin
		fail_count++;
		$error("done without fir_valid one cycle earlier");
	end

	// freq is held between frame results
	a_freq_hold: assert property (@(posedge clk) disable iff (rst)
		$changed(freq) |-> done)
	else begin
		fail_count++;
		$error("freq changed without done");
	end

	a_rst_quiet: assert property (@(posedge clk)
		rst |-> (!fir_valid && !done))
	else begin
		fail_count++;
		$error("strobe high during reset");
	end

endmodule

bind fas_top fas_props i_props (
	.clk        (clk),
	.rst        (rst),
	.data_valid (data_valid),
	.fir_valid  (fir_valid),
	.done       (done),
	.freq       (freq)
);

`default_nettype wire

/* verification/fas_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fas_params.svh"

module fas_tb;

	logic clk;
	logic rst;
	logic data_valid;
	fas_fir_pkg::sample_t data;
	fas_fir_pkg::sample_t fir_d;
	logic fir_valid;
	logic done;
	fas_peak_pkg::bin_idx_t freq;

	logic [31:0] lfsr;  // galois state seeded with 28
	int errors;
	int timeouts;

	// reference model state
	fas_fir_pkg::sample_t hist [`FAS_TAPS];  // hist[0] newest
	int fill;  // samples held since reset
	logic cur_valid;  // strobe driven for the coming edge
	fas_fir_pkg::sample_t cur_data;
	logic pend_valid;  // output expected after the next edge
	fas_fir_pkg::sample_t pend_d;
	logic done_pend;
	fas_peak_pkg::bin_idx_t exp_freq;
	int pos;  // frame position of the next output
	longint best_pow;
	int best_pos;

	fas_top i_dut (
		.clk        (clk),
		.rst        (rst),
		.data_valid (data_valid),
		.data       (data),
		.fir_d      (fir_d),
		.fir_valid  (fir_valid),
		.done       (done),
		.freq       (freq)
	);

	always #10 clk = ~clk;  // 20 ns period

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h80200003;  // maximal length mask
		end
		return s >> 1;
	endfunction

	task automatic draw_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[14:0], lfsr[0]};  // one step per bit
			lfsr = lfsr_step(lfsr);
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	// wrapped window sum with negative results bumped by one
	function automatic fas_fir_pkg::sample_t model_fir();
		longint acc;
		logic [31:0] s;
		acc = 0;
		for (int k = 0; k < `FAS_PAIRS; k++) begin
			acc += longint'(fas_fir_pkg::fir_coeffs[k])
				* (longint'(hist[k]) + longint'(hist[`FAS_TAPS-1-k]));
		end
		s = acc[31:0];
		return s[31:16] + {15'd0, s[31]};
	endfunction

	task automatic clear_model();
		for (int i = 0; i < `FAS_TAPS; i++) begin
			hist[i] = '0;
		end
		fill = 0;
		cur_valid = 1'b0;
		cur_data = '0;
		pend_valid = 1'b0;
		pend_d = '0;
		done_pend = 1'b0;
		exp_freq = '0;
		pos = 0;
		best_pow = 0;
		best_pos = 0;
	endtask

	// check the last edge's outputs then advance the model and drive
	task automatic step(input logic v, input fas_fir_pkg::sample_t d);
		longint pow;
		@(negedge clk);
		check_value("fir_valid", fir_valid, pend_valid);
		if (pend_valid) begin
			check_value("fir_d", fir_d, pend_d);
		end
		check_value("done", done, done_pend);
		if (done_pend) begin
			check_value("freq", freq, exp_freq);
		end
		done_pend = 1'b0;
		if (pend_valid) begin  // peak search on this cycle's output
			pow = longint'(pend_d) * longint'(pend_d);
			if (pos == 0 || pow > best_pow) begin
				best_pow = pow;
				best_pos = pos;
			end
			if (pos == `FAS_FRAME_LEN - 1) begin
				done_pend = 1'b1;
				exp_freq = fas_peak_pkg::bin_idx_t'(best_pos);
				pos = 0;
			end else begin
				pos++;
			end
		end
		pend_valid = 1'b0;
		if (cur_valid) begin  // sample taken at the edge just passed
			for (int i = `FAS_TAPS - 1; i > 0; i--) begin
				hist[i] = hist[i-1];
			end
			hist[0] = cur_data;
			if (fill < `FAS_TAPS) begin
				fill++;
			end
			if (fill == `FAS_TAPS) begin
				pend_valid = 1'b1;
				pend_d = model_fir();
			end
		end
		data_valid = v;
		data = d;
		cur_valid = v;
		cur_data = d;
	endtask

	task automatic random_step(input logic gaps);
		logic [15:0] vbits;
		logic [15:0] dbits;
		if (gaps) begin
			draw_bits(2, vbits);  // valid three cycles in four
		end else begin
			vbits = 16'd1;
		end
		draw_bits(16, dbits);
		step(vbits != 16'd0, fas_fir_pkg::sample_t'(dbits));
	endtask

	task automatic reset_dut(input int cycles);
		rst = 1'b1;  // async reset takes effect mid cycle
		data_valid = 1'b0;
		data = '0;
		clear_model();
		for (int i = 0; i < cycles; i++) begin
			@(negedge clk);
			check_value("fir_valid", fir_valid, 1'b0);
			check_value("done", done, 1'b0);
		end
		rst = 1'b0;
	endtask

	task automatic wait_fir_valid(input int limit);
		int t;
		t = 0;
		while (fir_valid !== 1'b1 && t < limit) begin
			step(1'b0, '0);
			t++;
		end
		if (fir_valid !== 1'b1) begin
			timeouts++;
			$display("timeout: fir_valid never came after a full window of samples");
		end
	endtask

	task automatic wait_done(input int limit);
		int t;
		t = 0;
		while (done !== 1'b1 && t < limit) begin
			random_step(1'b0);
			t++;
		end
		if (done !== 1'b1) begin
			timeouts++;
			$display("timeout: done never came at the end of a frame");
		end
	endtask

	initial begin
		int total;
		clk = 1'b0;
		rst = 1'b1;
		data_valid = 1'b0;
		data = '0;
		lfsr = 32'd28;
		errors = 0;
		timeouts = 0;
		reset_dut(10);
		for (int i = 0; i < `FAS_TAPS; i++) begin
			step(1'b1, '0);  // window of zeros
		end
		wait_fir_valid(4);
		for (int i = 0; i < 7; i++) begin
			step(1'b1, '0);  // impulse lands mid frame
		end
		step(1'b1, 16'h7FFF);  // impulse
		for (int i = 0; i < 56; i++) begin
			step(1'b1, '0);  // response with a centre tie then a zero frame
		end
		for (int i = 0; i < 300; i++) begin
			random_step(1'b1);  // random gaps
		end
		reset_dut(4);  // mid stream
		for (int i = 0; i < 32; i++) begin
			random_step(1'b0);
		end
		wait_fir_valid(4);
		for (int i = 0; i < 120; i++) begin
			random_step(1'b0);  // back to back
		end
		wait_done(40);
		for (int i = 0; i < 3; i++) begin
			step(1'b0, '0);  // drain the pipeline
		end
		total = errors + timeouts + i_dut.i_props.fail_count;
		$display("errors: %0d value, %0d timeout, %0d assertion",
			errors, timeouts, i_dut.i_props.fail_count);
		if (total == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
+incdir+common
common/fas_fir_pkg.sv
common/fas_peak_pkg.sv
fir/fir_tap_line.sv
fir/fir_mac.sv
design/peak_finder.sv
design/fas_top.sv
verification/fas_props.sv
verification/fas_tb.sv

/* Bender.yml */
package:
  name: fas

sources:
  - include_dirs:
      - common
    files:
      - common/fas_fir_pkg.sv
      - common/fas_peak_pkg.sv
      - fir/fir_tap_line.sv
      - fir/fir_mac.sv
      - design/peak_finder.sv
      - design/fas_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - verification/fas_props.sv
      - verification/fas_tb.sv
